/* design/div_stall_ctrl.sv */
`timescale 1ns/1ns
`include "pipe_defines.svh"

module div_stall_ctrl import pipe_stage_pkg::*, pipe_inst_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  stage_slot_t e_slot,
    output logic        alu_stall
);

    localparam int CNT_W = $clog2(`PIPE_DIV_CYCLES + 1);

    logic             e_is_div;
    logic             same_div;
    logic             busy;
    logic             start;
    logic             done;
    logic [CNT_W-1:0] cnt;
    tag_t             div_tag;

    assign e_is_div = e_slot.valid && (e_slot.inst.op == op_div);
    assign same_div = e_is_div && (e_slot.inst.tag == div_tag);  // still the counted divide
    assign busy     = (cnt != '0);
    assign start    = e_is_div && !(same_div && (busy || done));

    // first cycle, then while more than one count is left
    assign alu_stall = start || (same_div && (cnt > CNT_W'(1)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            done    <= 1'b0;
            div_tag <= '0;
        end else if (start) begin
            cnt     <= CNT_W'(`PIPE_DIV_CYCLES);
            done    <= 1'b0;
            div_tag <= e_slot.inst.tag;
        end else if (!same_div) begin
            cnt  <= '0;     // slot moved on or was flushed
            done <= 1'b0;
        end else if (busy) begin
            cnt  <= cnt - 1'b1;
            done <= (cnt == CNT_W'(1));
        end
    end

endmodule

/* design/inst_fifo.sv */
`timescale 1ns/1ns
`include "pipe_defines.svh"

module inst_fifo import pipe_inst_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  inst_t push_inst,
    input  logic  pop,
    output inst_t head,
    output logic  empty,
    output logic  full
);

    localparam int DEPTH = `PIPE_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    inst_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (PTR_W+1)'(DEPTH));
    assign head  = mem[rd_ptr];    // head seen before the pop

    // token storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_inst;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // push and pop together
            endcase
        end
    end

endmodule

/* design/pipe_ctrl_top.sv */
`timescale 1ns/1ns

module pipe_ctrl_top import pipe_inst_pkg::*, pipe_stage_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  inst_t push_inst,
    input  logic  mem_wait,
    output logic  full,
    output logic  retire_valid,
    output tag_t  retire_tag,
    output logic  retire_except
);

    inst_t        fifo_head;
    logic         fifo_empty;
    logic         fifo_pop;
    stage_slot_t  f_slot;
    stage_slot_t  d_q;
    stage_slot_t  e_q;
    stage_slot_t  m_q;
    retire_slot_t w_d;
    retire_slot_t w_q;
    logic         w_loaded;

    logic         f_ena;
    logic         d_ena;
    logic         e_ena;
    logic         m_ena;
    logic         w_ena;
    logic         d_flush;
    logic         e_flush;
    logic         m_flush;
    logic         w_flush;
    logic         fd_conflict_stall;

    logic         e_branch_taken;
    logic         e_mem_to_reg;
    reg_num_t     e_reg_waddr;
    logic         e_alu_stall;
    logic         m_except;

    // pop only into a decode register that takes it, or into a flush
    assign fifo_pop     = f_ena && (d_ena || fd_conflict_stall);
    assign f_slot.valid = !fifo_empty;
    assign f_slot.inst  = fifo_head;

    inst_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_inst (push_inst),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .full      (full)
    );

    pipe_stage_reg #(.slot_t(stage_slot_t)) u_d_reg (
        .clk (clk), .rst_n (rst_n), .ena (d_ena), .flush (d_flush),
        .d   (f_slot), .q (d_q), .loaded ()
    );

    pipe_stage_reg #(.slot_t(stage_slot_t)) u_e_reg (
        .clk (clk), .rst_n (rst_n), .ena (e_ena), .flush (e_flush),
        .d   (d_q), .q (e_q), .loaded ()
    );

    pipe_stage_reg #(.slot_t(stage_slot_t)) u_m_reg (
        .clk (clk), .rst_n (rst_n), .ena (m_ena), .flush (m_flush),
        .d   (e_q), .q (m_q), .loaded ()
    );

    // memory slot reduced to what retirement needs
    assign w_d.valid  = m_q.valid;
    assign w_d.tag    = m_q.inst.tag;
    assign w_d.except = (m_q.inst.op == op_except);

    pipe_stage_reg #(.slot_t(retire_slot_t)) u_w_reg (
        .clk (clk), .rst_n (rst_n), .ena (w_ena), .flush (w_flush),
        .d   (w_d), .q (w_q), .loaded (w_loaded)
    );

    div_stall_ctrl u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .e_slot    (e_q),
        .alu_stall (e_alu_stall)
    );

    // events seen by the hazard unit
    assign e_branch_taken = e_q.valid && (e_q.inst.op == op_branch_taken);
    assign e_mem_to_reg   = e_q.valid && (e_q.inst.op == op_load);
    assign e_reg_waddr    = e_q.inst.waddr;
    assign m_except       = m_q.valid && (m_q.inst.op == op_except);

    pipe_hazard u_hazard (
        .i_stall           (fifo_empty),
        .d_stall           (mem_wait),
        .d_read_rs         (d_q.valid && d_q.inst.read_rs),
        .d_read_rt         (d_q.valid && d_q.inst.read_rt),
        .d_rs              (d_q.inst.rs),
        .d_rt              (d_q.inst.rt),
        .e_mem_to_reg      (e_mem_to_reg),
        .e_reg_waddr       (e_reg_waddr),
        .e_branch_taken    (e_branch_taken),
        .e_alu_stall       (e_alu_stall),
        .m_except          (m_except),
        .fd_conflict_stall (fd_conflict_stall),
        .fd_wait_stall     (),
        .f_ena             (f_ena),
        .d_ena             (d_ena),
        .e_ena             (e_ena),
        .m_ena             (m_ena),
        .w_ena             (w_ena),
        .d_flush           (d_flush),
        .e_flush           (e_flush),
        .m_flush           (m_flush),
        .w_flush           (w_flush)
    );

    // a held writeback slot does not retire again
    assign retire_valid  = w_q.valid && w_loaded;
    assign retire_tag    = w_q.tag;
    assign retire_except = retire_valid && w_q.except;

endmodule

/* design/pipe_defines.svh */
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// register number carried by a token
`define PIPE_REG_W      5

// token tag, sequential in program order
`define PIPE_TAG_W      8

// entries in the fetch queue
`define PIPE_FIFO_DEPTH 8

// extra execute cycles a divide occupies
`define PIPE_DIV_CYCLES 4

`endif

/* design/pipe_hazard.sv */
`timescale 1ns/1ns
`include "pipe_defines.svh"

module pipe_hazard (
    input  logic                   i_stall,        // fetch queue empty
    input  logic                   d_stall,        // data memory not ready
    input  logic                   d_read_rs,
    input  logic                   d_read_rt,
    input  logic [`PIPE_REG_W-1:0] d_rs,
    input  logic [`PIPE_REG_W-1:0] d_rt,
    input  logic                   e_mem_to_reg,
    input  logic [`PIPE_REG_W-1:0] e_reg_waddr,
    input  logic                   e_branch_taken,
    input  logic                   e_alu_stall,
    input  logic                   m_except,
    output logic                   fd_conflict_stall,
    output logic                   fd_wait_stall,
    output logic                   f_ena,
    output logic                   d_ena,
    output logic                   e_ena,
    output logic                   m_ena,
    output logic                   w_ena,
    output logic                   d_flush,
    output logic                   e_flush,
    output logic                   m_flush,
    output logic                   w_flush
);

    logic rs_hit;
    logic rt_hit;
    logic lw_stall;
    logic br_go;
    logic is_flush;
    logic longest_stall;
    logic exc_flush;
    logic br_flush;

    // load in execute feeding a source decode reads
    assign rs_hit   = d_read_rs && (d_rs == e_reg_waddr);
    assign rt_hit   = d_read_rt && (d_rt == e_reg_waddr);
    assign lw_stall = e_mem_to_reg && (|e_reg_waddr) && (rs_hit || rt_hit);

    // a branch only redirects once execute can move on
    assign br_go    = e_branch_taken && !(e_alu_stall || d_stall);
    assign is_flush = m_except || br_go;

    assign fd_conflict_stall = !i_stall && is_flush;
    assign fd_wait_stall     = i_stall && is_flush;   // wait for a token to discard
    assign longest_stall     = e_alu_stall || d_stall || fd_wait_stall;

    assign exc_flush = m_except && !fd_wait_stall;
    assign br_flush  = br_go && !fd_wait_stall;

    assign f_ena = !i_stall;
    assign d_ena = !(lw_stall || longest_stall);
    assign e_ena = !longest_stall;
    assign m_ena = !longest_stall;
    assign w_ena = !longest_stall || exc_flush;   // excepting token always retires

    assign d_flush = exc_flush || br_flush;
    assign e_flush = exc_flush || br_flush || (lw_stall && !longest_stall); // load-use bubble
    assign m_flush = exc_flush;
    assign w_flush = 1'b0;

endmodule

/* design/pipe_inst_pkg.sv */
`include "pipe_defines.svh"

package pipe_inst_pkg;

    // what a token does, and so which hazard it can raise
    typedef enum logic [2:0] {
        op_alu,
        op_load,          // late result, load-use hazard
        op_div,           // multi-cycle in execute
        op_branch_taken,  // resolved in execute
        op_except         // raised in memory
    } op_kind_t;

    typedef logic [`PIPE_REG_W-1:0] reg_num_t;
    typedef logic [`PIPE_TAG_W-1:0] tag_t;

    typedef struct packed {
        tag_t     tag;
        op_kind_t op;
        reg_num_t rs;
        reg_num_t rt;
        logic     read_rs;
        logic     read_rt;
        reg_num_t waddr;    // zero means no destination
    } inst_t;

endpackage

/* design/pipe_stage_pkg.sv */
package pipe_stage_pkg;

    import pipe_inst_pkg::*;

    // decode, execute and memory slot
    typedef struct packed {
        logic  valid;
        inst_t inst;
    } stage_slot_t;

    // writeback keeps only what retirement reports
    typedef struct packed {
        logic valid;
        tag_t tag;
        logic except;
    } retire_slot_t;

endpackage

/* design/pipe_stage_reg.sv */
`timescale 1ns/1ns

module pipe_stage_reg import pipe_stage_pkg::*; #(
    parameter type slot_t = stage_slot_t
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ena,
    input  logic  flush,
    input  slot_t d,
    output slot_t q,
    output logic  loaded
);

    // flush wins over a hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q      <= '0;
            loaded <= 1'b0;
        end else begin
            if (flush) begin
                q <= '0;          // bubble, valid clear
            end else if (ena) begin
                q <= d;
            end
            loaded <= flush || ena;   // new contents on this edge
        end
    end

endmodule

/* pipe_ctrl.f */
+incdir+design
design/pipe_inst_pkg.sv
design/pipe_stage_pkg.sv
design/inst_fifo.sv
design/pipe_stage_reg.sv
design/div_stall_ctrl.sv
design/pipe_hazard.sv
design/pipe_ctrl_top.sv
sim/tb_pipe_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# compile and run tb_pipe_ctrl with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f pipe_ctrl.f --top-module tb_pipe_ctrl -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_pipe_ctrl)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1

/* sim/tb_pipe_ctrl.sv */
`timescale 1ns/1ns
`include "pipe_defines.svh"

module tb_pipe_ctrl import pipe_inst_pkg::*, pipe_stage_pkg::*; ();

    localparam int MAX_PROG  = 64;
    localparam int PAD       = 3;                      // trailing alu tokens without a destination
    localparam int DIV_GAP   = `PIPE_DIV_CYCLES + 1;
    localparam int TOTAL_LEN = (12 + 24 + 12 + 16 + 16 + 16 + 48) + 7 * PAD;
    localparam int TIMEOUT   = TOTAL_LEN * (`PIPE_DIV_CYCLES + 2) + 50;

    logic         clk;
    logic         rst_n;
    logic         push;
    inst_t        push_inst;
    logic         mem_wait;
    logic         full;
    logic         retire_valid;
    tag_t         retire_tag;
    logic         retire_except;
    retire_slot_t got_slot;

    integer       seed = 32'hf4c7;
    inst_t        prog [MAX_PROG];
    retire_slot_t exp_slot [MAX_PROG];
    int           exp_gap [MAX_PROG];
    int           prog_len;
    int           exp_count;
    int           push_idx;
    int           ret_idx;
    int           cycle;
    int           last_cycle;
    logic         feeding;
    logic         wait_on;
    logic         check_gaps;

    pipe_ctrl_top u_pipe_ctrl_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_inst     (push_inst),
        .mem_wait      (mem_wait),
        .full          (full),
        .retire_valid  (retire_valid),
        .retire_tag    (retire_tag),
        .retire_except (retire_except)
    );

    assign got_slot = '{valid: retire_valid, tag: retire_tag, except: retire_except};

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_retire(input retire_slot_t got, input retire_slot_t exp);
        if (got !== exp) begin
            abort_run($sformatf(
                "Mismatch retire_tag got %h expected %h, retire_except got %h expected %h",
                got.tag, exp.tag, got.except, exp.except));
        end
    endtask

    task automatic check_gap(input int got, input int exp, input tag_t tag);
        if (got != exp) begin
            abort_run($sformatf("Mismatch retire_valid gap at tag %h got %h expected %h",
                tag, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // one bubble when the next token reads a load's real destination
    function automatic bit reads_load(input inst_t ld, input inst_t cur);
        if (ld.op != op_load || ld.waddr == '0) begin
            return 1'b0;
        end
        return (cur.read_rs && cur.rs == ld.waddr) || (cur.read_rt && cur.rt == ld.waddr);
    endfunction

    function automatic op_kind_t pick_op(input int mode);
        int r;
        r = rand_below(8);
        case (mode)
            2: return (r < 4) ? op_load : op_alu;
            3: return (r < 3) ? op_div : op_alu;
            4: return (r < 2) ? op_branch_taken : op_alu;
            5: return (r < 2) ? op_except : op_alu;
            6: begin
                case (r)
                    3: return op_load;
                    4: return op_div;
                    5: return op_branch_taken;
                    6: return op_except;
                    default: return op_alu;
                endcase
            end
            default: return op_alu;
        endcase
    endfunction

    function automatic void gen_program(input int mode, input int len);
        int    i;
        inst_t t;
        prog_len = len + PAD;
        for (i = 0; i < prog_len; i++) begin
            t.tag     = tag_t'(i);                 // sequential tags
            t.op      = pick_op(mode);
            t.rs      = reg_num_t'(rand_below(4)); // few registers so sources often match
            t.rt      = reg_num_t'(rand_below(4));
            t.read_rs = (rand_below(2) == 1);
            t.read_rt = (rand_below(2) == 1);
            t.waddr   = reg_num_t'(rand_below(4));
            if (i >= len) begin
                t.op      = op_alu;
                t.read_rs = 1'b0;
                t.read_rt = 1'b0;
                t.waddr   = '0;
            end
            prog[i] = t;
        end
    endfunction

    // expected retire list with two followers dropped per taken branch and three per exception
    function automatic void build_expected();
        int i;
        int skip;
        exp_count = 0;
        skip = 0;
        for (i = 0; i < prog_len; i++) begin
            if (skip > 0) begin
                skip--;
            end else begin
                exp_slot[exp_count] = '{valid: 1'b1, tag: prog[i].tag,
                                        except: (prog[i].op == op_except)};
                exp_gap[exp_count] = 1;
                if (i + 1 < prog_len && prog[i + 1].op == op_div) begin
                    exp_gap[exp_count] = DIV_GAP;  // memory stage held behind the divide
                end else if (i > 0 && reads_load(prog[i - 1], prog[i])) begin
                    exp_gap[exp_count] = 2;
                end
                case (prog[i].op)
                    op_branch_taken: skip = 2;
                    op_except:       skip = 3;
                    default:         skip = 0;
                endcase
                exp_count++;
            end
        end
    endfunction

    // queue feeder and mem_wait pulses
    always @(negedge clk) begin
        if (feeding && !full && push_idx < prog_len) begin
            push      = 1'b1;
            push_inst = prog[push_idx];
            push_idx  = push_idx + 1;
        end else begin
            push = 1'b0;
        end
        mem_wait = wait_on ? (rand_below(4) == 0) : 1'b0;
    end

    always @(negedge clk) begin
        if (retire_valid) begin
            if (ret_idx >= exp_count) begin
                abort_run($sformatf("Mismatch retire_valid got %h expected %h at tag %h",
                    retire_valid, 1'b0, retire_tag));
            end else begin
                check_retire(got_slot, exp_slot[ret_idx]);
                if (check_gaps && ret_idx > 0) begin
                    check_gap(cycle - last_cycle, exp_gap[ret_idx], retire_tag);
                end
                last_cycle = cycle;
                ret_idx    = ret_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d tokens retired",
                cycle, ret_idx, exp_count));
        end
    end

    task automatic run_test(input int mode, input int len, input bit gaps, input bit waits);
        gen_program(mode, len);
        build_expected();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        check_flag("retire_valid", retire_valid, 1'b0);
        check_flag("full", full, 1'b0);
        rst_n = 1'b1;
        @(posedge clk);
        push_idx   = 0;
        ret_idx    = 0;
        check_gaps = gaps;
        wait_on    = waits;
        feeding    = 1'b1;
        while (ret_idx < exp_count) begin
            @(posedge clk);
        end
        feeding = 1'b0;
        wait_on = 1'b0;
        repeat (8) @(posedge clk);   // extra strobes caught by the compare process
        @(negedge clk);
        check_flag("full", full, 1'b0);
    endtask

    initial begin
        rst_n      = 1'b0;
        push       = 1'b0;
        push_inst  = '0;
        mem_wait   = 1'b0;
        feeding    = 1'b0;
        wait_on    = 1'b0;
        check_gaps = 1'b0;
        prog_len   = 0;
        exp_count  = 0;
        push_idx   = 0;
        ret_idx    = 0;
        cycle      = 0;
        last_cycle = 0;
        run_test(1, 12, 1'b1, 1'b0);   // independent alu
        run_test(2, 24, 1'b1, 1'b0);   // load-use
        run_test(3, 12, 1'b1, 1'b0);   // divides
        run_test(4, 16, 1'b0, 1'b0);   // taken branches
        run_test(4, 16, 1'b0, 1'b1);
        run_test(5, 16, 1'b0, 1'b0);   // exceptions
        run_test(6, 48, 1'b0, 1'b1);   // random mix with mem_wait
        $display("RESULT: PASS");
        $finish;
    end

endmodule
